// File: verilog.f
verilog/bpu_pkg.sv
verilog/branch_decode.sv
verilog/bht.sv
verilog/btb.sv
verilog/bpu.sv
verilog/bpu_top.sv
dv/bpu_assert.sv
dv/bpu_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module bpu_tb -Mdir obj_dir -f verilog.f
	./obj_dir/Vbpu_tb | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/bpu_tb.sv
`timescale 1ns/1ns

module bpu_tb;

    import bpu_pkg::*;

    localparam int BHT_BITS = 6;
    localparam int BTB_BITS = 4;
    localparam int TIMEOUT  = 50;
    // conditional branch with opcode 010110 and a plain non-branch word
    localparam inst_t COND_BR = {6'b010110, 26'h0000123};
    localparam inst_t NOP     = 32'h0000_0000;

    logic  clk = 1'b0;
    logic  rst_n, stall, flush;
    logic  inst_en_1, inst_en_2;
    logic  update_en, update_taken;
    addr_t fetch_pc, update_pc, update_target, pred_target;
    inst_t inst_1, inst_2;
    logic  is_branch_1, is_branch_2, pred_taken, fetch_inst_2_en, next_valid;

    // reference tables
    counter_t bht_model [1 << BHT_BITS];
    logic     btb_valid [1 << BTB_BITS];
    addr_t    btb_tag   [1 << BTB_BITS];
    addr_t    btb_dest  [1 << BTB_BITS];

    logic [15:0] lfsr;
    int          errors;
    int          timeouts;
    logic        exp_br_1, exp_br_2, exp_taken, exp_inst_2_en, exp_next_valid;
    addr_t       exp_target;

    bpu_top #(.BHT_INDEX_BITS(BHT_BITS), .BTB_INDEX_BITS(BTB_BITS)) i_dut (.*);

    always #10 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic branch_op(inst_t inst);
        return (inst[31:26] >= OP_BRANCH_FIRST) && (inst[31:26] <= OP_BRANCH_LAST);
    endfunction

    function automatic logic uncond_op(inst_t inst);
        return (inst[31:26] == OP_JIRL) || (inst[31:26] == OP_B) || (inst[31:26] == OP_BL);
    endfunction

    // enabled branch, btb hit, and unconditional or counter at 2 or 3
    function automatic logic model_taken(addr_t pc, inst_t inst, logic en);
        logic [BTB_BITS-1:0] ti;
        ti = pc[BTB_BITS+1:2];
        return en && branch_op(inst) && btb_valid[ti]
            && (btb_tag[ti] == (pc >> (BTB_BITS + 2)))
            && (uncond_op(inst) || (bht_model[pc[BHT_BITS+1:2]] >= 2'd2));
    endfunction

    task automatic predict(addr_t pc, inst_t i1, inst_t i2, logic en1, logic en2, logic fl);
        addr_t pc_2;
        logic  take_1;
        logic  take_2;
        pc_2   = pc + 32'd4;
        take_1 = model_taken(pc, i1, en1);
        take_2 = model_taken(pc_2, i2, en2);
        exp_br_1   = en1 && branch_op(i1);
        exp_br_2   = en2 && branch_op(i2);
        exp_taken  = take_1 || take_2;
        exp_target = take_1 ? btb_dest[pc[BTB_BITS+1:2]]
                   : (take_2 ? btb_dest[pc_2[BTB_BITS+1:2]] : '0);
        exp_inst_2_en  = take_1 ? 1'b0 : (take_2 ? 1'b1 : en2);
        exp_next_valid = !(take_1 || fl);
    endtask

    task automatic check_value(string test, string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test, name, exp, act);
        end
    endtask

    task automatic check_outputs(string test);
        @(negedge clk);
        check_value(test, "is_branch_1", 32'(exp_br_1), 32'(is_branch_1));
        check_value(test, "is_branch_2", 32'(exp_br_2), 32'(is_branch_2));
        check_value(test, "pred_taken", 32'(exp_taken), 32'(pred_taken));
        check_value(test, "pred_target", exp_target, pred_target);
        check_value(test, "fetch_inst_2_en", 32'(exp_inst_2_en), 32'(fetch_inst_2_en));
        check_value(test, "next_valid", 32'(exp_next_valid), 32'(next_valid));
    endtask

    // one update pulse that also steps the reference tables
    task automatic train(addr_t pc, logic taken, addr_t target);
        logic [BHT_BITS-1:0] bi;
        logic [BTB_BITS-1:0] ti;
        bi = pc[BHT_BITS+1:2];
        ti = pc[BTB_BITS+1:2];
        @(posedge clk);
        update_en     <= 1'b1;
        update_pc     <= pc;
        update_taken  <= taken;
        update_target <= target;
        if (taken && bht_model[bi] != 2'd3) begin
            bht_model[bi] = bht_model[bi] + 2'd1;
        end else if (!taken && bht_model[bi] != 2'd0) begin
            bht_model[bi] = bht_model[bi] - 2'd1;
        end
        if (taken) begin
            btb_valid[ti] = 1'b1;
            btb_tag[ti]   = pc >> (BTB_BITS + 2);
            btb_dest[ti]  = target;
        end
    endtask

    // pc goes out one cycle ahead of the instructions
    task automatic lookup(string test, addr_t pc, inst_t i1, inst_t i2,
                          logic en1, logic en2, logic fl);
        predict(pc, i1, i2, en1, en2, fl);
        @(posedge clk);
        update_en <= 1'b0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        fetch_pc  <= pc;
        @(posedge clk);
        inst_1    <= i1;
        inst_2    <= i2;
        inst_en_1 <= en1;
        inst_en_2 <= en2;
        flush     <= fl;
        check_outputs(test);
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((next_valid !== 1'b1 || pred_taken !== 1'b0) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (next_valid !== 1'b1 || pred_taken !== 1'b0) begin
            timeouts++;
            $display("timeout: outputs did not settle to the reset state");
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = i_dut.i_bpu.i_bpu_assert.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic decode_test();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] en;
        logic [31:0] pc;
        for (int n = 0; n < 40; n++) begin
            take_bits(32, r1);
            take_bits(32, r2);
            take_bits(2, en);
            take_bits(13, pc);
            lookup("decode", pc << 3, r1, r2, en[0], en[1], 1'b0);
        end
    endtask

    task automatic counter_test();
        // T T T N N N N T T T walks the counter into both ends
        logic [9:0] seq;
        seq = 10'b1110000111;
        for (int n = 9; n >= 0; n--) begin
            train(32'h1000, seq[n], 32'h1400);
            lookup("counter", 32'h1000, COND_BR, NOP, 1'b1, 1'b1, 1'b0);
        end
    endtask

    task automatic uncond_test();
        // counter back to weakly not taken while the btb entry stays
        train(32'h2010, 1'b1, 32'h2800);
        train(32'h2010, 1'b0, 32'h2c00);
        lookup("uncond_b", 32'h2010, {OP_B, 26'h40}, NOP, 1'b1, 1'b1, 1'b0);
        lookup("uncond_bl", 32'h2010, {OP_BL, 26'h40}, NOP, 1'b1, 1'b1, 1'b0);
        lookup("uncond_jirl", 32'h2010, {OP_JIRL, 26'h40}, NOP, 1'b1, 1'b1, 1'b0);
        lookup("uncond_cond", 32'h2010, COND_BR, NOP, 1'b1, 1'b1, 1'b0);
        // same btb index with another tag
        lookup("uncond_alias", 32'h2410, {OP_B, 26'h40}, NOP, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic priority_test();
        train(32'h3020, 1'b1, 32'h3800);
        train(32'h3024, 1'b1, 32'h3900);
        lookup("priority_both", 32'h3020, COND_BR, COND_BR, 1'b1, 1'b1, 1'b0);
        train(32'h4034, 1'b1, 32'h4a00);
        lookup("priority_slot2", 32'h4030, COND_BR, COND_BR, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic stall_test();
        lookup("stall_first", 32'h3020, COND_BR, COND_BR, 1'b1, 1'b1, 1'b0);
        @(posedge clk);
        stall    <= 1'b1;
        fetch_pc <= 32'h5038;
        for (int n = 0; n < 3; n++) begin
            check_outputs("stall_hold");
        end
        @(posedge clk);
        stall <= 1'b0;
        check_outputs("stall_release");
        predict(32'h5038, COND_BR, COND_BR, 1'b1, 1'b1, 1'b0);
        check_outputs("stall_new");
    endtask

    task automatic flush_test();
        lookup("flush_slot1", 32'h3020, COND_BR, COND_BR, 1'b1, 1'b1, 1'b1);
        lookup("flush_slot2", 32'h4030, COND_BR, COND_BR, 1'b1, 1'b1, 1'b1);
        lookup("flush_none", 32'h5038, NOP, NOP, 1'b1, 1'b0, 1'b1);
    endtask

    initial begin
        rst_n         = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        fetch_pc      = '0;
        inst_1        = '0;
        inst_2        = '0;
        inst_en_1     = 1'b0;
        inst_en_2     = 1'b0;
        update_en     = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        lfsr          = 16'd15;
        errors        = 0;
        timeouts      = 0;
        for (int i = 0; i < (1 << BHT_BITS); i++) begin
            bht_model[i] = COUNTER_INIT;
        end
        for (int i = 0; i < (1 << BTB_BITS); i++) begin
            btb_valid[i] = 1'b0;
            btb_tag[i]   = '0;
            btb_dest[i]  = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_done();
        if (timeouts == 0) begin
            decode_test();
            counter_test();
            uncond_test();
            priority_test();
            stall_test();
            flush_test();
        end
        finish_run();
    end

endmodule

// File: dv/bpu_assert.sv
`timescale 1ns/1ns

module bpu_assert (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           is_branch_1,
    input  logic           is_branch_2,
    input  logic           pred_taken,
    input  bpu_pkg::addr_t pred_target,
    input  logic           next_valid
);

    int fail_count = 0;

    // a taken prediction needs a decoded branch in some slot
    taken_has_branch: assert property (
        @(posedge clk) disable iff (!rst_n)
        pred_taken |-> (is_branch_1 || is_branch_2)
    ) else begin
        fail_count++;
        $error("pred_taken is high with no branch in either slot");
    end

    // target stays zero without a prediction
    target_zero_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !pred_taken |-> (pred_target == '0)
    ) else begin
        fail_count++;
        $error("pred_target is not zero while pred_taken is low");
    end

    flush_kills_next: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |-> !next_valid
    ) else begin
        fail_count++;
        $error("next_valid is high during flush");
    end

endmodule

bind bpu bpu_assert i_bpu_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .is_branch_1 (is_branch_1),
    .is_branch_2 (is_branch_2),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .next_valid  (next_valid)
);

// File: verilog/bpu_top.sv
`timescale 1ns/1ns

module bpu_top #(
    parameter int BHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  bpu_pkg::addr_t fetch_pc,
    input  bpu_pkg::inst_t inst_1,
    input  bpu_pkg::inst_t inst_2,
    input  logic           inst_en_1,
    input  logic           inst_en_2,
    input  logic           update_en,
    input  bpu_pkg::addr_t update_pc,
    input  logic           update_taken,
    input  bpu_pkg::addr_t update_target,
    input  logic           flush,
    output logic           is_branch_1,
    output logic           is_branch_2,
    output logic           pred_taken,
    output bpu_pkg::addr_t pred_target,
    output logic           fetch_inst_2_en,
    output logic           next_valid
);

    // table sizes are chosen here and passed down
    bpu #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) i_bpu (
        .clk,
        .rst_n,
        .stall,
        .fetch_pc,
        .inst_1,
        .inst_2,
        .inst_en_1,
        .inst_en_2,
        .update_en,
        .update_pc,
        .update_taken,
        .update_target,
        .flush,
        .is_branch_1,
        .is_branch_2,
        .pred_taken,
        .pred_target,
        .fetch_inst_2_en,
        .next_valid
    );

endmodule

// File: verilog/bpu.sv
`timescale 1ns/1ns

module bpu #(
    parameter int BHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  bpu_pkg::addr_t fetch_pc,
    input  bpu_pkg::inst_t inst_1,
    input  bpu_pkg::inst_t inst_2,
    input  logic           inst_en_1,
    input  logic           inst_en_2,
    input  logic           update_en,
    input  bpu_pkg::addr_t update_pc,
    input  logic           update_taken,
    input  bpu_pkg::addr_t update_target,
    input  logic           flush,
    output logic           is_branch_1,
    output logic           is_branch_2,
    output logic           pred_taken,
    output bpu_pkg::addr_t pred_target,
    output logic           fetch_inst_2_en,
    output logic           next_valid
);

    import bpu_pkg::*;

    addr_t    fetch_pc_2;
    logic     dec_branch_1, dec_branch_2;
    logic     dec_uncond_1, dec_uncond_2;
    counter_t counter_1, counter_2;
    logic     hit_1, hit_2;
    addr_t    target_1, target_2;
    logic     taken_1, taken_2;

    // second slot of the aligned pair
    assign fetch_pc_2 = fetch_pc + 32'd4;

    ////////////////////
    // datapath blocks
    ////////////////////

    branch_decode i_dec_1 (
        .inst      (inst_1),
        .is_branch (dec_branch_1),
        .is_uncond (dec_uncond_1)
    );

    branch_decode i_dec_2 (
        .inst      (inst_2),
        .is_branch (dec_branch_2),
        .is_uncond (dec_uncond_2)
    );

    bht #(.BHT_INDEX_BITS(BHT_INDEX_BITS)) i_bht (
        .clk, .rst_n, .stall,
        .lookup_pc_1 (fetch_pc),
        .lookup_pc_2 (fetch_pc_2),
        .update_en, .update_pc, .update_taken,
        .counter_1, .counter_2
    );

    btb #(.BTB_INDEX_BITS(BTB_INDEX_BITS)) i_btb (
        .clk, .rst_n, .stall,
        .lookup_pc_1 (fetch_pc),
        .lookup_pc_2 (fetch_pc_2),
        .update_en, .update_pc, .update_taken, .update_target,
        .hit_1, .hit_2, .target_1, .target_2
    );

    ////////////////////
    // slot selection
    ////////////////////

    assign is_branch_1 = inst_en_1 && dec_branch_1;
    assign is_branch_2 = inst_en_2 && dec_branch_2;

    // counter msb set means 2 or 3, i.e. taken
    assign taken_1 = is_branch_1 && hit_1 && (dec_uncond_1 || counter_1[1]);
    assign taken_2 = is_branch_2 && hit_2 && (dec_uncond_2 || counter_2[1]);

    // slot 1 wins, the second instruction is then dropped
    always_comb begin
        if (taken_1) begin
            pred_taken      = 1'b1;
            pred_target     = target_1;
            fetch_inst_2_en = 1'b0;
        end else if (taken_2) begin
            pred_taken      = 1'b1;
            pred_target     = target_2;
            fetch_inst_2_en = 1'b1;
        end else begin
            pred_taken      = 1'b0;
            pred_target     = '0;
            fetch_inst_2_en = inst_en_2;
        end
    end

    // sequential fetch after a taken slot 1 is wrong path
    assign next_valid = !(taken_1 || flush);

endmodule

// File: verilog/btb.sv
`timescale 1ns/1ns

module btb #(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  bpu_pkg::addr_t lookup_pc_1,
    input  bpu_pkg::addr_t lookup_pc_2,
    input  logic           update_en,
    input  bpu_pkg::addr_t update_pc,
    input  logic           update_taken,
    input  bpu_pkg::addr_t update_target,
    output logic           hit_1,
    output logic           hit_2,
    output bpu_pkg::addr_t target_1,
    output bpu_pkg::addr_t target_2
);

    import bpu_pkg::*;

    localparam int BTB_ENTRIES = 1 << BTB_INDEX_BITS;
    // everything above the index
    localparam int TAG_BITS    = 32 - BTB_INDEX_BITS - 2;

    logic                valid_mem  [BTB_ENTRIES];
    logic [TAG_BITS-1:0] tag_mem    [BTB_ENTRIES];
    addr_t               target_mem [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] idx_1;
    logic [BTB_INDEX_BITS-1:0] idx_2;
    logic [BTB_INDEX_BITS-1:0] update_idx;
    logic [TAG_BITS-1:0]       tag_1;
    logic [TAG_BITS-1:0]       tag_2;
    logic [TAG_BITS-1:0]       update_tag;
    logic                      wr_en;

    assign idx_1      = lookup_pc_1[BTB_INDEX_BITS+1:2];
    assign idx_2      = lookup_pc_2[BTB_INDEX_BITS+1:2];
    assign update_idx = update_pc[BTB_INDEX_BITS+1:2];
    assign tag_1      = lookup_pc_1[31:BTB_INDEX_BITS+2];
    assign tag_2      = lookup_pc_2[31:BTB_INDEX_BITS+2];
    assign update_tag = update_pc[31:BTB_INDEX_BITS+2];

    // only taken branches allocate, not taken leaves the entry alone
    assign wr_en = update_en && update_taken;

    ////////////////////
    // entry write
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_mem[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_mem[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[update_idx]    <= update_tag;
            target_mem[update_idx] <= update_target;
        end
    end

    ////////////////////
    // registered lookup
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_1    <= 1'b0;
            hit_2    <= 1'b0;
            target_1 <= '0;
            target_2 <= '0;
        end else if (!stall) begin
            hit_1    <= valid_mem[idx_1] && (tag_mem[idx_1] == tag_1);
            hit_2    <= valid_mem[idx_2] && (tag_mem[idx_2] == tag_2);
            target_1 <= target_mem[idx_1];
            target_2 <= target_mem[idx_2];
        end
    end

endmodule

// File: verilog/bht.sv
`timescale 1ns/1ns

module bht #(
    parameter int BHT_INDEX_BITS = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  bpu_pkg::addr_t    lookup_pc_1,
    input  bpu_pkg::addr_t    lookup_pc_2,
    input  logic              update_en,
    input  bpu_pkg::addr_t    update_pc,
    input  logic              update_taken,
    output bpu_pkg::counter_t counter_1,
    output bpu_pkg::counter_t counter_2
);

    import bpu_pkg::*;

    localparam int BHT_ENTRIES = 1 << BHT_INDEX_BITS;

    counter_t cnt_mem [BHT_ENTRIES];

    logic [BHT_INDEX_BITS-1:0] idx_1;
    logic [BHT_INDEX_BITS-1:0] idx_2;
    logic [BHT_INDEX_BITS-1:0] update_idx;

    // word index, bits 1:0 are always zero
    assign idx_1      = lookup_pc_1[BHT_INDEX_BITS+1:2];
    assign idx_2      = lookup_pc_2[BHT_INDEX_BITS+1:2];
    assign update_idx = update_pc[BHT_INDEX_BITS+1:2];

    // count up on taken, down otherwise, stick at both ends
    function automatic counter_t next_count(counter_t cur, logic taken);
        counter_t nxt;
        if (taken) begin
            nxt = (cur == 2'd3) ? cur : cur + 2'd1;
        end else begin
            nxt = (cur == 2'd0) ? cur : cur - 2'd1;
        end
        return nxt;
    endfunction

    ////////////////////
    // training
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt_mem[i] <= COUNTER_INIT;
            end
        end else if (update_en) begin
            cnt_mem[update_idx] <= next_count(cnt_mem[update_idx], update_taken);
        end
    end

    ////////////////////
    // registered lookup
    ////////////////////

    // a same-cycle update is not forwarded, the read gets the old value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counter_1 <= '0;
            counter_2 <= '0;
        end else if (!stall) begin
            counter_1 <= cnt_mem[idx_1];
            counter_2 <= cnt_mem[idx_2];
        end
    end

endmodule

// File: verilog/branch_decode.sv
`timescale 1ns/1ns

module branch_decode (
    input  bpu_pkg::inst_t inst,
    output logic           is_branch,
    output logic           is_uncond
);

    import bpu_pkg::*;

    opcode_t opcode;

    // major opcode only, the rest of the word does not matter here
    assign opcode = inst[31:26];

    ////////////////////
    // branch range check
    ////////////////////

    always_comb begin
        if ((opcode >= OP_BRANCH_FIRST) && (opcode <= OP_BRANCH_LAST)) begin
            is_branch = 1'b1;
        end else begin
            is_branch = 1'b0;
        end
    end

    ////////////////////
    // unconditional kinds
    ////////////////////

    // jirl, b and bl always redirect
    // all three sit inside the branch range
    always_comb begin
        case (opcode)
            OP_JIRL: is_uncond = 1'b1;
            OP_B:    is_uncond = 1'b1;
            OP_BL:   is_uncond = 1'b1;
            default: is_uncond = 1'b0;
        endcase
    end

endmodule

// File: verilog/bpu_pkg.sv
package bpu_pkg;

    ////////////////////
    // basic word types
    ////////////////////

    // byte address, one word wide
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // major opcode field, bits 31 to 26 of an instruction
    typedef logic [5:0] opcode_t;

    // 2-bit saturating counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] counter_t;

    ////////////////////
    // counter encoding
    ////////////////////

    // weakly not taken
    localparam counter_t COUNTER_INIT = 2'd1;

    ////////////////////
    // branch opcodes
    ////////////////////

    // whole branch range, inclusive at both ends
    localparam opcode_t OP_BRANCH_FIRST = 6'b010010;
    localparam opcode_t OP_BRANCH_LAST  = 6'b011011;

    // unconditional branches
    localparam opcode_t OP_JIRL = 6'b010011;
    localparam opcode_t OP_B    = 6'b010100;
    localparam opcode_t OP_BL   = 6'b010101;

endpackage
